// ==== verilog/screenPkg.sv ====
package screenPkg;

    // screen and layout geometry, in pixels
    localparam int SCREEN_WIDTH  = 240;
    localparam int SCREEN_HEIGHT = 240;
    localparam int BUTTON_WIDTH  = 40;
    localparam int BUTTON_HEIGHT = 90;
    localparam int MARGIN_WIDTH  = 25;
    localparam int MARGIN_HEIGHT = 20;
    localparam int SPACE         = 10;

    // one scanned pixel position
    typedef struct packed {
        logic [8:0] x;
        logic [7:0] y;
        logic       valid;
    } pixelCoord_t;

    typedef enum logic [2:0] {
        COLOR_BG,
        COLOR_STAGE,
        COLOR_HIGHLIGHT,
        COLOR_BUTTON,
        COLOR_DIGIT
    } pixelColor_e;

    // colour tagged with the coordinate it belongs to
    typedef struct packed {
        pixelCoord_t coord;
        pixelColor_e color;
    } pixelOut_t;

endpackage

// ==== verilog/memGamePkg.sv ====
package memGamePkg;

    typedef enum logic [0:0] {
        ST_PLAY,
        ST_SOLVED
    } gameState_e;

    // stage index, 0 up to NUM_STAGES-1
    typedef logic [2:0] stage_t;

    // what the puzzle reports to the outside
    typedef struct packed {
        stage_t     stage;
        logic [1:0] memPos;   // highlighted button, 0 is the rightmost
        logic       strike;   // one-cycle pulse on a wrong press
        logic       solved;   // sticky until reset
    } puzzleStatus_t;

endpackage

// ==== verilog/pixelScanner.sv ====
`timescale 1ns/100ps

module pixelScanner (
    input  logic                  clk,
    input  logic                  nrst,
    output screenPkg::pixelCoord_t coord
);

    logic lastCol;
    logic lastRow;

    assign lastCol = (coord.x == 9'(screenPkg::SCREEN_WIDTH - 1));
    assign lastRow = (coord.y == 8'(screenPkg::SCREEN_HEIGHT - 1));

    always_ff @(posedge clk) begin
        if (!nrst) begin
            coord <= '0;
        end else begin
            coord.valid <= 1'b1;
            // hold (0,0) for the first valid cycle, then run the raster
            if (coord.valid) begin
                if (lastCol) begin
                    coord.x <= '0;
                    if (lastRow) begin
                        coord.y <= '0;
                    end else begin
                        coord.y <= coord.y + 8'd1;
                    end
                end else begin
                    coord.x <= coord.x + 9'd1;
                end
            end
        end
    end

endmodule

// ==== verilog/memGameControl.sv ====
`timescale 1ns/100ps

module memGameControl #(
    parameter int NUM_STAGES = 5
) (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic [2*NUM_STAGES-1:0]     displayNumBus,  // 2 bits per stage
    input  logic [8*NUM_STAGES-1:0]     labelNumBus,    // 4 labels x 2 bits per stage
    input  logic                        moveLeft,
    input  logic                        moveRight,
    input  logic                        press,
    output memGamePkg::puzzleStatus_t   status
);

    memGamePkg::gameState_e state;
    memGamePkg::stage_t     stage;
    logic [1:0]             memPos;
    logic                   strike;

    logic [1:0] displayDigit;
    logic [1:0] selectedLabel;
    logic       correct;
    logic       lastStage;

    // digits for the current stage
    assign displayDigit  = displayNumBus[int'(stage) * 2 +: 2];
    assign selectedLabel = labelNumBus[int'(stage) * 8 + int'(memPos) * 2 +: 2];
    assign correct       = (selectedLabel == displayDigit);
    assign lastStage     = (stage == 3'(NUM_STAGES - 1));

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state  <= memGamePkg::ST_PLAY;
            stage  <= '0;
            memPos <= '0;
            strike <= 1'b0;
        end else begin
            strike <= 1'b0;    // pulse only
            if (state == memGamePkg::ST_PLAY) begin
                // buttons are indexed from the right edge of the screen,
                // so left means a higher index; 2-bit wrap does 3->0 and 0->3
                if (moveLeft && !moveRight) begin
                    memPos <= memPos + 2'd1;
                end else if (moveRight && !moveLeft) begin
                    memPos <= memPos - 2'd1;
                end

                if (press) begin
                    if (!correct) begin
                        strike <= 1'b1;
                        stage  <= '0;
                    end else if (lastStage) begin
                        state <= memGamePkg::ST_SOLVED;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
            end
        end
    end

    assign status.stage  = stage;
    assign status.memPos = memPos;
    assign status.strike = strike;
    assign status.solved = (state == memGamePkg::ST_SOLVED);

endmodule

// ==== verilog/memPixelGen.sv ====
`timescale 1ns/100ps

module memPixelGen #(
    parameter int NUM_STAGES = 5
) (
    input  logic                    clk,
    input  logic                    nrst,
    input  screenPkg::pixelCoord_t  coordIn,
    input  logic [2*NUM_STAGES-1:0] displayNumBus,
    input  logic [8*NUM_STAGES-1:0] labelNumBus,
    input  memGamePkg::stage_t      stage,
    input  logic [1:0]              memPos,
    output screenPkg::pixelCoord_t  coordOut,
    output logic                    displayPixel,
    output logic                    buttonPixel,
    output logic [3:0]              labelPixel,
    output logic                    stagePixel,
    output logic                    buttonHighlightPixel
);

    localparam int PITCH = screenPkg::BUTTON_WIDTH + screenPkg::SPACE;
    localparam int RIGHT_EDGE = screenPkg::SCREEN_WIDTH - screenPkg::MARGIN_WIDTH;
    localparam int BTN_TOP = screenPkg::MARGIN_HEIGHT;
    localparam int BTN_BOTTOM = screenPkg::MARGIN_HEIGHT + screenPkg::BUTTON_HEIGHT;
    localparam int LOWER_TOP = BTN_BOTTOM + screenPkg::MARGIN_HEIGHT;  // display and lights

    logic       displayHit;
    logic       buttonHit;
    logic [3:0] labelHit;
    logic       stageHit;
    logic       highlightHit;
    int         px;
    int         py;

    // 5 wide, 20 tall bar with tapered ends; cx is its right column
    function automatic logic vertBar(input int x, input int y, input int cx, input int cy);
        int d;
        int taper;
        d = cx - x;
        taper = (d == 2) ? 0 : ((d == 1 || d == 3) ? 1 : 2);
        return (d >= 0) && (d <= 4) && (y >= cy + taper) && (y <= cy + 19 - taper);
    endfunction

    // 20 wide, 5 tall bar; cx is its right end
    function automatic logic horiBar(input int x, input int y, input int cx, input int cy);
        int d;
        int taper;
        d = y - cy;
        taper = (d == 2) ? 0 : ((d == 1 || d == 3) ? 1 : 2);
        return (d >= 0) && (d <= 4) && (x <= cx - taper) && (x >= cx - 19 + taper);
    endfunction

    // segment set for digit values 0..3, drawn as one..four
    function automatic logic [6:0] segments(input logic [1:0] digit);
        case (digit)
            2'd0:    return 7'b0000110;
            2'd1:    return 7'b1011011;
            2'd2:    return 7'b1001111;
            default: return 7'b1100110;
        endcase
    endfunction

    function automatic logic digitHit(input int x, input int y, input int ax, input int ay,
                                      input logic [6:0] seg);
        logic hit;
        hit = 1'b0;
        if (seg[6]) hit |= horiBar(x, y, ax - 10, ay + 45);
        if (seg[5]) hit |= vertBar(x, y, ax - 10, ay + 45);
        if (seg[4]) hit |= vertBar(x, y, ax - 10, ay + 25);
        if (seg[3]) hit |= horiBar(x, y, ax - 10, ay + 25);
        if (seg[2]) hit |= vertBar(x, y, ax - 30, ay + 25);
        if (seg[1]) hit |= vertBar(x, y, ax - 30, ay + 45);
        if (seg[0]) hit |= horiBar(x, y, ax - 10, ay + 65);
        return hit;
    endfunction

    assign px = int'(coordIn.x);
    assign py = int'(coordIn.y);

    always_comb begin
        int hlRight;
        buttonHit    = 1'b0;
        labelHit     = '0;
        stageHit     = 1'b0;
        hlRight      = RIGHT_EDGE - int'(memPos) * PITCH;

        for (int i = 0; i < 4; i++) begin
            if (px < RIGHT_EDGE - i * PITCH && px > RIGHT_EDGE - i * PITCH - screenPkg::BUTTON_WIDTH
                && py > BTN_TOP && py < BTN_BOTTOM) begin
                buttonHit = 1'b1;
            end
            labelHit[i] = digitHit(px, py, RIGHT_EDGE - i * PITCH, BTN_TOP + 10,
                                   segments(labelNumBus[int'(stage) * 8 + i * 2 +: 2]));
        end

        // display digit sits left of the buttons' right margin
        displayHit = digitHit(px, py, RIGHT_EDGE - screenPkg::BUTTON_WIDTH - screenPkg::MARGIN_WIDTH,
                              LOWER_TOP, segments(displayNumBus[int'(stage) * 2 +: 2]));

        // selected button grown by 5 on each side
        highlightHit = (px < hlRight + 5) && (px > hlRight - screenPkg::BUTTON_WIDTH - 5)
                       && (py > BTN_TOP - 5) && (py < BTN_BOTTOM + 5);

        // lights stack down under the leftmost button column
        for (int k = 0; k < NUM_STAGES; k++) begin
            if (k <= int'(stage)
                && px < RIGHT_EDGE - 3 * PITCH && px > RIGHT_EDGE - 3 * PITCH - screenPkg::BUTTON_WIDTH
                && py > LOWER_TOP + k * 2 * screenPkg::SPACE
                && py < LOWER_TOP + k * 2 * screenPkg::SPACE + screenPkg::SPACE) begin
                stageHit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            coordOut.valid <= 1'b0;
        end else begin
            coordOut <= coordIn;
        end
    end

    // flags follow the coordinate through the same stage
    always_ff @(posedge clk) begin
        displayPixel         <= displayHit;
        buttonPixel          <= buttonHit;
        labelPixel           <= labelHit;
        stagePixel           <= stageHit;
        buttonHighlightPixel <= highlightHit;
    end

endmodule

// ==== verilog/pixelColorMux.sv ====
`timescale 1ns/100ps

module pixelColorMux (
    input  logic                   clk,
    input  logic                   nrst,
    input  screenPkg::pixelCoord_t coordIn,
    input  logic                   displayPixel,
    input  logic                   buttonPixel,
    input  logic [3:0]             labelPixel,
    input  logic                   stagePixel,
    input  logic                   buttonHighlightPixel,
    output screenPkg::pixelOut_t   pixelOut
);

    screenPkg::pixelColor_e color;

    // digits drawn over buttons, buttons over the highlight rim
    always_comb begin
        if (displayPixel || (|labelPixel)) begin
            color = screenPkg::COLOR_DIGIT;
        end else if (buttonPixel) begin
            color = screenPkg::COLOR_BUTTON;
        end else if (buttonHighlightPixel) begin
            color = screenPkg::COLOR_HIGHLIGHT;
        end else if (stagePixel) begin
            color = screenPkg::COLOR_STAGE;
        end else begin
            color = screenPkg::COLOR_BG;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            pixelOut.coord.valid <= 1'b0;
        end else begin
            pixelOut.coord <= coordIn;
        end
    end

    always_ff @(posedge clk) begin
        pixelOut.color <= color;
    end

endmodule

// ==== verilog/memGameTop.sv ====
`timescale 1ns/100ps

module memGameTop #(
    parameter int NUM_STAGES = 5
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic [2*NUM_STAGES-1:0]   displayNumBus,
    input  logic [8*NUM_STAGES-1:0]   labelNumBus,
    input  logic                      moveLeft,
    input  logic                      moveRight,
    input  logic                      press,
    output memGamePkg::puzzleStatus_t status,
    output screenPkg::pixelOut_t      pixelOut
);

    screenPkg::pixelCoord_t scanCoord;
    screenPkg::pixelCoord_t genCoord;     // one cycle behind scanCoord
    logic                   displayPixel;
    logic                   buttonPixel;
    logic [3:0]             labelPixel;
    logic                   stagePixel;
    logic                   buttonHighlightPixel;

    pixelScanner u_pixelScanner (
        .clk   (clk),
        .nrst  (nrst),
        .coord (scanCoord)
    );

    memGameControl #(.NUM_STAGES(NUM_STAGES)) u_memGameControl (
        .clk           (clk),
        .nrst          (nrst),
        .displayNumBus (displayNumBus),
        .labelNumBus   (labelNumBus),
        .moveLeft      (moveLeft),
        .moveRight     (moveRight),
        .press         (press),
        .status        (status)
    );

    memPixelGen #(.NUM_STAGES(NUM_STAGES)) u_memPixelGen (
        .clk                  (clk),
        .nrst                 (nrst),
        .coordIn              (scanCoord),
        .displayNumBus        (displayNumBus),
        .labelNumBus          (labelNumBus),
        .stage                (status.stage),
        .memPos               (status.memPos),
        .coordOut             (genCoord),
        .displayPixel         (displayPixel),
        .buttonPixel          (buttonPixel),
        .labelPixel           (labelPixel),
        .stagePixel           (stagePixel),
        .buttonHighlightPixel (buttonHighlightPixel)
    );

    pixelColorMux u_pixelColorMux (
        .clk                  (clk),
        .nrst                 (nrst),
        .coordIn              (genCoord),
        .displayPixel         (displayPixel),
        .buttonPixel          (buttonPixel),
        .labelPixel           (labelPixel),
        .stagePixel           (stagePixel),
        .buttonHighlightPixel (buttonHighlightPixel),
        .pixelOut             (pixelOut)
    );

endmodule

// ==== verif/clkGen.sv ====
`timescale 1ns/100ps

module clkGen #(
    parameter int PERIOD = 8   // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// ==== verif/memGame_sva.sv ====
`timescale 1ns/100ps

module memGame_sva #(
    parameter int NUM_STAGES = 5
) (
    input logic                      clk,
    input logic                      nrst,
    input logic                      press,
    input memGamePkg::puzzleStatus_t status,
    input screenPkg::pixelOut_t      pixelOut
);

    int         failCount = 0;   // read by the testbench at the end
    logic       lastCol;
    logic       lastRow;
    logic [8:0] nextX;
    logic [7:0] nextY;

    // where the following raster pixel should land
    assign lastCol = (pixelOut.coord.x == 9'(screenPkg::SCREEN_WIDTH - 1));
    assign lastRow = (pixelOut.coord.y == 8'(screenPkg::SCREEN_HEIGHT - 1));
    assign nextX   = lastCol ? 9'd0 : pixelOut.coord.x + 9'd1;
    assign nextY   = !lastCol ? pixelOut.coord.y : (lastRow ? 8'd0 : pixelOut.coord.y + 8'd1);

    rasterOrder: assert property (@(posedge clk) disable iff (!nrst)
        pixelOut.coord.valid |=> pixelOut.coord.valid
            && pixelOut.coord.x == $past(nextX) && pixelOut.coord.y == $past(nextY))
        else begin
            failCount++;
            $error("pixel stream left raster order or dropped valid");
        end

    firstPixel: assert property (@(posedge clk) disable iff (!nrst)
        $rose(pixelOut.coord.valid) |-> pixelOut.coord.x == 9'd0 && pixelOut.coord.y == 8'd0)
        else begin
            failCount++;
            $error("first valid pixel is not (0,0)");
        end

    strikeNeedsPress: assert property (@(posedge clk) disable iff (!nrst)
        status.strike |-> $past(press))
        else begin
            failCount++;
            $error("strike without a press in the previous cycle");
        end

    stageInRange: assert property (@(posedge clk) disable iff (!nrst)
        int'(status.stage) < NUM_STAGES)
        else begin
            failCount++;
            $error("stage above the last stage");
        end

    solvedSticky: assert property (@(posedge clk) disable iff (!nrst)
        status.solved |=> status.solved)
        else begin
            failCount++;
            $error("solved dropped before reset");
        end

endmodule

bind memGameTop memGame_sva #(.NUM_STAGES(NUM_STAGES)) u_memGameSva (
    .clk      (clk),
    .nrst     (nrst),
    .press    (press),
    .status   (status),
    .pixelOut (pixelOut)
);

// ==== verif/memGameTb.sv ====
`timescale 1ns/100ps

module memGameTb;

    localparam int NUM_STAGES = 5;
    localparam int FRAME = screenPkg::SCREEN_WIDTH * screenPkg::SCREEN_HEIGHT;
    localparam int MAX_CYCLES = 150000;   // two captured frames plus setup, ~2.5 frames

    logic                      clk;
    logic                      nrst;
    logic [2*NUM_STAGES-1:0]   displayNumBus;
    logic [8*NUM_STAGES-1:0]   labelNumBus;
    logic                      moveLeft;
    logic                      moveRight;
    logic                      press;
    memGamePkg::puzzleStatus_t status;
    screenPkg::pixelOut_t      pixelOut;

    int   errors = 0;
    int   cycles = 0;
    int   probeCount = 0;
    logic probeOn = 1'b0;
    int   dispDigit [NUM_STAGES];
    int   labels [NUM_STAGES][4];
    int   expStage = 0;           // reference model of the puzzle
    int   expPos = 0;
    logic expSolved = 1'b0;

    clkGen #(.PERIOD(8)) u_clkGen (.clk(clk));

    memGameTop #(.NUM_STAGES(NUM_STAGES)) u_memGameTop (.*);

    task automatic checkValue(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            errors++;
            $display("** Error %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic checkStatus(input logic expStrike);
        checkValue("status.stage", expStage, int'(status.stage));
        checkValue("status.memPos", expPos, int'(status.memPos));
        checkValue("status.strike", int'(expStrike), int'(status.strike));
        checkValue("status.solved", int'(expSolved), int'(status.solved));
    endtask

    // random display digit and label permutation for every stage
    task automatic newPuzzle();
        int j;
        int t;
        for (int s = 0; s < NUM_STAGES; s++) begin
            dispDigit[s] = int'($urandom % 4);
            for (int i = 0; i < 4; i++) labels[s][i] = i;
            for (int i = 3; i > 0; i--) begin
                j = int'($urandom % (i + 1));
                t = labels[s][i];
                labels[s][i] = labels[s][j];
                labels[s][j] = t;
            end
            displayNumBus[s*2 +: 2] = 2'(dispDigit[s]);
            for (int i = 0; i < 4; i++) labelNumBus[s*8 + i*2 +: 2] = 2'(labels[s][i]);
        end
    endtask

    // one-cycle pulse, 0 left, 1 right, 2 press; called on a falling edge
    task automatic pulse(input int which);
        logic wrong;
        wrong     = 1'b0;
        moveLeft  = (which == 0);
        moveRight = (which == 1);
        press     = (which == 2);
        if (!expSolved) begin
            if (which == 0) expPos = (expPos + 1) % 4;   // left is the higher index
            if (which == 1) expPos = (expPos + 3) % 4;
            if (which == 2) begin
                wrong = (labels[expStage][expPos] != dispDigit[expStage]);
                if (wrong) expStage = 0;
                else if (expStage == NUM_STAGES - 1) expSolved = 1'b1;
                else expStage++;
            end
        end
        @(negedge clk);
        moveLeft  = 1'b0;
        moveRight = 1'b0;
        press     = 1'b0;
        checkStatus(wrong);
        if (wrong) begin
            @(negedge clk);
            checkStatus(1'b0);   // strike is gone again
        end
    endtask

    task automatic pressCorrect();
        while (labels[expStage][expPos] != dispDigit[expStage]) pulse(0);
        pulse(2);
    endtask

    task automatic pressWrong();
        while (labels[expStage][expPos] == dispDigit[expStage]) pulse(1);
        pulse(2);
    endtask

    // layout model away from digit segments
    function automatic screenPkg::pixelColor_e regionColor(input int x, input int y);
        int re;
        int pitch;
        int bot;
        int top;
        re    = screenPkg::SCREEN_WIDTH - screenPkg::MARGIN_WIDTH;
        pitch = screenPkg::BUTTON_WIDTH + screenPkg::SPACE;
        bot   = screenPkg::MARGIN_HEIGHT + screenPkg::BUTTON_HEIGHT;
        for (int i = 0; i < 4; i++) begin
            if (x < re - i * pitch && x > re - i * pitch - screenPkg::BUTTON_WIDTH
                && y > screenPkg::MARGIN_HEIGHT && y < bot) return screenPkg::COLOR_BUTTON;
        end
        re = re - expPos * pitch;   // right edge of the highlighted button
        if (x < re + 5 && x > re - screenPkg::BUTTON_WIDTH - 5
            && y > screenPkg::MARGIN_HEIGHT - 5 && y < bot + 5) return screenPkg::COLOR_HIGHLIGHT;
        for (int k = 0; k <= expStage; k++) begin
            top = bot + screenPkg::MARGIN_HEIGHT + 2 * k * screenPkg::SPACE;
            if (x > screenPkg::MARGIN_WIDTH && x < screenPkg::MARGIN_WIDTH + screenPkg::BUTTON_WIDTH
                && y > top && y < top + screenPkg::SPACE) return screenPkg::COLOR_STAGE;
        end
        return screenPkg::COLOR_BG;
    endfunction

    // button corner, highlight rim, light centres and one background pixel
    function automatic logic isProbe(input int x, input int y);
        int rim;
        rim = screenPkg::SCREEN_WIDTH - screenPkg::MARGIN_WIDTH + 2
              - expPos * (screenPkg::BUTTON_WIDTH + screenPkg::SPACE);
        if (x == 178 && y == 25) return 1'b1;
        if (x == rim && y == 60) return 1'b1;
        if (x == 5 && y == 5) return 1'b1;
        return (x == 45) && (y >= 135) && (y <= 135 + 20 * (NUM_STAGES - 1))
               && ((y - 135) % 20 == 0);
    endfunction

    always @(negedge clk) begin
        int x;
        int y;
        x = int'(pixelOut.coord.x);
        y = int'(pixelOut.coord.y);
        if (probeOn && pixelOut.coord.valid && isProbe(x, y)) begin
            probeCount++;
            checkValue("pixelOut.color", int'(regionColor(x, y)), int'(pixelOut.color));
        end
    end

    // one full frame of pixels under the current status
    task automatic captureFrame();
        repeat (3) @(negedge clk);   // flush pixels made under the old status
        @(posedge clk);
        probeOn = 1'b1;
        repeat (FRAME) @(posedge clk);
        probeOn = 1'b0;
        @(negedge clk);
    endtask

    task automatic endRun();
        $display("checks failed: %0d, assertion failures: %0d", errors,
                 u_memGameTop.u_memGameSva.failCount);
        if (errors + u_memGameTop.u_memGameSva.failCount == 0) $display("sim passed");
        else $display("sim failed");
        $finish;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            errors++;
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            endRun();
        end
    end

    initial begin
        void'($urandom(85));
        nrst          = 1'b0;
        moveLeft      = 1'b0;
        moveRight     = 1'b0;
        press         = 1'b0;
        displayNumBus = '0;
        labelNumBus   = '0;
        newPuzzle();
        repeat (4) @(negedge clk);
        checkStatus(1'b0);
        checkValue("pixelOut.coord.valid", 0, int'(pixelOut.coord.valid));
        nrst = 1'b1;

        repeat (5) pulse(0);   // passes 3 -> 0
        repeat (2) pulse(1);   // passes 0 -> 3
        pressCorrect();
        pressCorrect();
        pressWrong();          // back to stage 0
        pressCorrect();
        pressCorrect();
        captureFrame();        // mid game, stage 2

        repeat (3) pressCorrect();
        checkValue("status.solved", 1, int'(status.solved));
        pulse(0);              // all ignored once solved
        pulse(2);
        pulse(1);
        captureFrame();        // every light on
        checkValue("probe count", 16, probeCount);
        endRun();
    end

endmodule

// ==== src.f ====
verilog/screenPkg.sv
verilog/memGamePkg.sv
verilog/pixelScanner.sv
verilog/memGameControl.sv
verilog/memPixelGen.sv
verilog/pixelColorMux.sv
verilog/memGameTop.sv
verif/clkGen.sv
verif/memGame_sva.sv
verif/memGameTb.sv

// ==== run_sim.sh ====
#!/bin/bash
# builds the memGame testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module memGameTb -f src.f -o memGameSim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/memGameSim +verilator+error+limit+1000 > sim.log 2>&1
runStatus=$?
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus, see sim.log"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    echo "FAIL, see sim.log"
    exit 1
fi
echo "PASS"
exit 0
